//--- source/vseq_defines.svh
/*
  Sizing macros for the vector sequencer
  VSEQ_NR_VINSN must be a power of two so IDs fill their field
  The ALU queue is assumed to be the deepest, counters are sized from it
*/
`ifndef VSEQ_DEFINES_SVH
`define VSEQ_DEFINES_SVH

// Parallel lanes, each one runs every ALU instruction
`define VSEQ_NR_LANES 4
// Instruction IDs that may be in flight at once
`define VSEQ_NR_VINSN 8
// Architectural vector registers
`define VSEQ_NR_VREGS 32

// Per-unit instruction queue depths
`define VSEQ_ALU_DEPTH 4
`define VSEQ_LD_DEPTH 2
`define VSEQ_ST_DEPTH 2

// Lanes, then load unit, then store unit
`define VSEQ_NR_PES (`VSEQ_NR_LANES + 2)

`endif

//--- source/vseq_pkg.sv
/*
  Shared types of the vector sequencer
  Field widths follow the sizing macros, hazard vectors hold one bit per ID
*/
`default_nettype none

`include "vseq_defines.svh"

package vseq_pkg;

  // Widths that carry a meaning
  typedef logic [$clog2(`VSEQ_NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(`VSEQ_NR_VREGS)-1:0] vreg_t;
  typedef logic [`VSEQ_NR_VINSN-1:0]         vinsn_vec_t;
  typedef logic [15:0]                       vl_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_MUL,
    OP_LOAD,
    OP_STORE
  } vop_e;

  // Values double as index into per-unit vectors
  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_LOAD  = 2'd1,
    UNIT_STORE = 2'd2
  } unit_e;

  typedef enum logic {
    ISSUE_IDLE,
    ISSUE_HOLD
  } issue_state_e;

  // Decoded instruction from the dispatcher
  typedef struct packed {
    vop_e  op;
    vreg_t vs1;
    logic  use_vs1;
    vreg_t vs2;
    logic  use_vs2;
    vreg_t vd;
    logic  use_vd;
    vl_t   vl;
  } seq_req_t;

  // Request broadcast to all PEs
  typedef struct packed {
    vid_t       id;
    vop_e       op;
    unit_e      unit;
    vreg_t      vs1;
    logic       use_vs1;
    vreg_t      vs2;
    logic       use_vs2;
    vreg_t      vd;
    logic       use_vd;
    vl_t        vl;
    vinsn_vec_t hazard_vs1;
    vinsn_vec_t hazard_vs2;
    vinsn_vec_t hazard_vd;
  } pe_req_t;

  // Last reader or writer of one vector register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  // Unit that executes an operation
  function automatic unit_e unit_of(vop_e op);
    case (op)
      OP_LOAD:  unit_of = UNIT_LOAD;
      OP_STORE: unit_of = UNIT_STORE;
      default:  unit_of = UNIT_ALU;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- source/vinsn_tracker.sv
/*
  Tracks which instruction ID runs on which PE
  An ALU instruction occupies every lane, a memory one only its unit
  Done bits must only hit IDs that are running on that PE
  The free ID search sees completions one cycle after the done pulse
*/
`timescale 1ns/1ps
`default_nettype none

`include "vseq_defines.svh"

module vinsn_tracker (
  input  wire                                          clk_i,
  input  wire                                          rst_ni,
  input  wire                                          issue_i,
  input  vseq_pkg::vid_t                               issue_id_i,
  input  vseq_pkg::unit_e                              issue_unit_i,
  input  vseq_pkg::vinsn_vec_t [`VSEQ_NR_PES-1:0]      pe_done_i,
  output vseq_pkg::vinsn_vec_t                         running_o,
  output vseq_pkg::vid_t                               next_id_o,
  output logic                                         full_o,
  output logic                                         idle_o
);

  // One row per PE, one column per ID
  vseq_pkg::vinsn_vec_t [`VSEQ_NR_PES-1:0] pe_running_d, pe_running_q;

  always_comb begin
    pe_running_d = pe_running_q;
    // Retire first
    for (int pe = 0; pe < `VSEQ_NR_PES; pe++) begin
      pe_running_d[pe] &= ~pe_done_i[pe];
    end
    // Then mark the newly issued ID
    if (issue_i) begin
      case (issue_unit_i)
        vseq_pkg::UNIT_LOAD:  pe_running_d[`VSEQ_NR_LANES][issue_id_i]     = 1'b1;
        vseq_pkg::UNIT_STORE: pe_running_d[`VSEQ_NR_LANES + 1][issue_id_i] = 1'b1;
        default: begin
          for (int l = 0; l < `VSEQ_NR_LANES; l++) begin
            pe_running_d[l][issue_id_i] = 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_running_q <= '0;
    end else begin
      pe_running_q <= pe_running_d;
    end
  end

  // ID busy anywhere in the unit
  always_comb begin
    running_o = '0;
    for (int pe = 0; pe < `VSEQ_NR_PES; pe++) begin
      running_o |= pe_running_q[pe];
    end
  end

  // Lowest free ID, the last hit of a downward scan wins
  always_comb begin
    next_id_o = '0;
    full_o    = 1'b1;
    for (int i = `VSEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        next_id_o = vseq_pkg::vid_t'(i);
        full_o    = 1'b0;
      end
    end
  end

  assign idle_o = ~|running_o;

endmodule

`default_nettype wire

//--- source/vreg_scoreboard.sv
/*
  Register scoreboard for RAW, WAR and WAW detection
  Only the latest reader and writer of each register are remembered
  Entries and table columns drop out once their ID stops running
  Hazard outputs are combinational on the incoming request
*/
`timescale 1ns/1ps
`default_nettype none

`include "vseq_defines.svh"

module vreg_scoreboard (
  input  wire                                          clk_i,
  input  wire                                          rst_ni,
  input  vseq_pkg::seq_req_t                           seq_req_i,
  input  wire                                          issue_i,
  input  vseq_pkg::vid_t                               issue_id_i,
  input  vseq_pkg::vinsn_vec_t                         running_i,
  output vseq_pkg::vinsn_vec_t                         hazard_vs1_o,
  output vseq_pkg::vinsn_vec_t                         hazard_vs2_o,
  output vseq_pkg::vinsn_vec_t                         hazard_vd_o,
  output vseq_pkg::vinsn_vec_t [`VSEQ_NR_VINSN-1:0]    hazard_table_o
);

  vseq_pkg::vreg_access_t [`VSEQ_NR_VREGS-1:0] read_list_d, read_list_q;
  vseq_pkg::vreg_access_t [`VSEQ_NR_VREGS-1:0] write_list_d, write_list_q;
  vseq_pkg::vinsn_vec_t   [`VSEQ_NR_VINSN-1:0] table_d, table_q;
  vseq_pkg::vinsn_vec_t                        hz_vs1, hz_vs2, hz_vd;

  always_comb begin
    read_list_d  = read_list_q;
    write_list_d = write_list_q;

    // Forget accesses of retired instructions
    for (int v = 0; v < `VSEQ_NR_VREGS; v++) begin
      read_list_d[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
      write_list_d[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end

    hz_vs1 = '0;
    hz_vs2 = '0;
    hz_vd  = '0;

    // RAW on the sources
    if (seq_req_i.use_vs1 && write_list_d[seq_req_i.vs1].valid)
      hz_vs1[write_list_d[seq_req_i.vs1].vid] = 1'b1;
    if (seq_req_i.use_vs2 && write_list_d[seq_req_i.vs2].valid)
      hz_vs2[write_list_d[seq_req_i.vs2].vid] = 1'b1;

    if (seq_req_i.use_vd) begin
      // WAR, the pending reader of vd blocks every operand
      if (read_list_d[seq_req_i.vd].valid) begin
        hz_vs1[read_list_d[seq_req_i.vd].vid] = 1'b1;
        hz_vs2[read_list_d[seq_req_i.vd].vid] = 1'b1;
        hz_vd[read_list_d[seq_req_i.vd].vid]  = 1'b1;
      end
      // WAW
      if (write_list_d[seq_req_i.vd].valid)
        hz_vd[write_list_d[seq_req_i.vd].vid] = 1'b1;
    end

    // Clear columns of IDs no longer running
    for (int r = 0; r < `VSEQ_NR_VINSN; r++) begin
      table_d[r] = table_q[r] & running_i;
    end

    // Record the issued instruction
    if (issue_i) begin
      if (seq_req_i.use_vd)
        write_list_d[seq_req_i.vd] = '{vid: issue_id_i, valid: 1'b1};
      if (seq_req_i.use_vs1)
        read_list_d[seq_req_i.vs1] = '{vid: issue_id_i, valid: 1'b1};
      if (seq_req_i.use_vs2)
        read_list_d[seq_req_i.vs2] = '{vid: issue_id_i, valid: 1'b1};
      table_d[issue_id_i] = hz_vs1 | hz_vs2 | hz_vd;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
      table_q      <= '0;
    end else begin
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
      table_q      <= table_d;
    end
  end

  assign hazard_vs1_o   = hz_vs1;
  assign hazard_vs2_o   = hz_vs2;
  assign hazard_vd_o    = hz_vd;
  assign hazard_table_o = table_q;

endmodule

`default_nettype wire

//--- source/unit_queue_cnt.sv
/*
  In-flight counters for the ALU, load and store queues
  At most one completion per unit and cycle is counted
  Counter width is taken from the ALU depth, the deepest queue
*/
`timescale 1ns/1ps
`default_nettype none

`include "vseq_defines.svh"

module unit_queue_cnt (
  input  wire             clk_i,
  input  wire             rst_ni,
  input  wire             issue_i,
  input  vseq_pkg::unit_e issue_unit_i,
  input  wire  [2:0]      done_i,
  output logic [2:0]      unit_ready_o
);

  localparam int unsigned CNT_W = $clog2(`VSEQ_ALU_DEPTH + 1);

  // Indexed by unit_e value
  localparam int unsigned DEPTH [3] = '{`VSEQ_ALU_DEPTH, `VSEQ_LD_DEPTH, `VSEQ_ST_DEPTH};

  for (genvar u = 0; u < 3; u++) begin : gen_cnt
    logic [CNT_W-1:0] cnt_q;
    logic             up;

    assign up = issue_i && (issue_unit_i == vseq_pkg::unit_e'(u));

    // Issue and completion together leave the count unchanged
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (up && !done_i[u]) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!up && done_i[u]) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    // Room for one more instruction
    assign unit_ready_o[u] = (cnt_q < CNT_W'(DEPTH[u]));
  end

endmodule

`default_nettype wire

//--- source/vseq_issue.sv
/*
  Issue control between dispatcher and PEs
  One request at a time, held until every lane takes it
  Load and store readiness comes from the queue counters only
*/
`timescale 1ns/1ps
`default_nettype none

`include "vseq_defines.svh"

module vseq_issue (
  input  wire                                 clk_i,
  input  wire                                 rst_ni,
  input  vseq_pkg::seq_req_t                  seq_req_i,
  input  wire                                 req_valid_i,
  input  vseq_pkg::vid_t                      next_id_i,
  input  wire                                 full_i,
  input  wire  [2:0]                          unit_ready_i,
  input  vseq_pkg::vinsn_vec_t                hazard_vs1_i,
  input  vseq_pkg::vinsn_vec_t                hazard_vs2_i,
  input  vseq_pkg::vinsn_vec_t                hazard_vd_i,
  input  wire  [`VSEQ_NR_LANES-1:0]           pe_req_ready_i,
  output logic                                req_ready_o,
  output logic                                issue_o,
  output vseq_pkg::vid_t                      issue_id_o,
  output vseq_pkg::unit_e                     issue_unit_o,
  output vseq_pkg::pe_req_t                   pe_req_o,
  output logic                                pe_req_valid_o
);

  vseq_pkg::issue_state_e state_d, state_q;
  vseq_pkg::pe_req_t      pe_req_d, pe_req_q;
  vseq_pkg::unit_e        unit;

  assign unit = vseq_pkg::unit_of(seq_req_i.op);

  //////////////////////////////
  // Handshake and FSM
  //////////////////////////////

  always_comb begin
    state_d     = state_q;
    req_ready_o = 1'b0;
    case (state_q)
      vseq_pkg::ISSUE_IDLE: begin
        // Needs a free ID and room in the target queue
        req_ready_o = !full_i && unit_ready_i[unit];
        if (req_valid_i && req_ready_o)
          state_d = vseq_pkg::ISSUE_HOLD;
      end
      vseq_pkg::ISSUE_HOLD: begin
        // All lanes must take it in the same cycle
        if (&pe_req_ready_i)
          state_d = vseq_pkg::ISSUE_IDLE;
      end
      default: state_d = vseq_pkg::ISSUE_IDLE;
    endcase
  end

  assign issue_o      = req_valid_i && req_ready_o;
  assign issue_id_o   = next_id_i;
  assign issue_unit_o = unit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= vseq_pkg::ISSUE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // PE request
  //////////////////////////////

  always_comb begin
    pe_req_d = '{
      id:         next_id_i,
      op:         seq_req_i.op,
      unit:       unit,
      vs1:        seq_req_i.vs1,
      use_vs1:    seq_req_i.use_vs1,
      vs2:        seq_req_i.vs2,
      use_vs2:    seq_req_i.use_vs2,
      vd:         seq_req_i.vd,
      use_vd:     seq_req_i.use_vd,
      vl:         seq_req_i.vl,
      hazard_vs1: hazard_vs1_i,
      hazard_vs2: hazard_vs2_i,
      hazard_vd:  hazard_vd_i
    };
  end

  // Loaded only on transfer, so it stays put under back-pressure
  always_ff @(posedge clk_i) begin
    if (issue_o)
      pe_req_q <= pe_req_d;
  end

  assign pe_req_o       = pe_req_q;
  assign pe_req_valid_o = (state_q == vseq_pkg::ISSUE_HOLD);

endmodule

`default_nettype wire

//--- source/vseq_top.sv
/*
  Vector instruction sequencer top level
  PE order is lanes first, then load unit, then store unit
  ALU queue completion follows lane 0 only
  Load and store ready bits are not used, their counters guard them
*/
`timescale 1ns/1ps
`default_nettype none

`include "vseq_defines.svh"

module vseq_top (
  input  wire                                         clk_i,
  input  wire                                         rst_ni,
  input  vseq_pkg::seq_req_t                          seq_req_i,
  input  wire                                         req_valid_i,
  output logic                                        req_ready_o,
  output vseq_pkg::pe_req_t                           pe_req_o,
  output logic                                        pe_req_valid_o,
  input  wire  [`VSEQ_NR_PES-1:0]                     pe_req_ready_i,
  input  vseq_pkg::vinsn_vec_t [`VSEQ_NR_PES-1:0]     pe_done_i,
  output vseq_pkg::vinsn_vec_t [`VSEQ_NR_VINSN-1:0]   hazard_table_o,
  output logic                                        idle_o
);

  logic                 issue;
  vseq_pkg::vid_t       issue_id;
  vseq_pkg::unit_e      issue_unit;
  vseq_pkg::vinsn_vec_t running;
  vseq_pkg::vid_t       next_id;
  logic                 full;
  logic [2:0]           unit_ready;
  logic [2:0]           unit_done;
  vseq_pkg::vinsn_vec_t hazard_vs1, hazard_vs2, hazard_vd;

  // One completion flag per unit, in unit_e order
  assign unit_done[vseq_pkg::UNIT_ALU]   = |pe_done_i[0];
  assign unit_done[vseq_pkg::UNIT_LOAD]  = |pe_done_i[`VSEQ_NR_LANES];
  assign unit_done[vseq_pkg::UNIT_STORE] = |pe_done_i[`VSEQ_NR_LANES + 1];

  vinsn_tracker i_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_id_i   (issue_id),
    .issue_unit_i (issue_unit),
    .pe_done_i    (pe_done_i),
    .running_o    (running),
    .next_id_o    (next_id),
    .full_o       (full),
    .idle_o       (idle_o)
  );

  vreg_scoreboard i_scoreboard (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .seq_req_i      (seq_req_i),
    .issue_i        (issue),
    .issue_id_i     (issue_id),
    .running_i      (running),
    .hazard_vs1_o   (hazard_vs1),
    .hazard_vs2_o   (hazard_vs2),
    .hazard_vd_o    (hazard_vd),
    .hazard_table_o (hazard_table_o)
  );

  unit_queue_cnt i_queue_cnt (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_unit_i (issue_unit),
    .done_i       (unit_done),
    .unit_ready_o (unit_ready)
  );

  vseq_issue i_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .seq_req_i      (seq_req_i),
    .req_valid_i    (req_valid_i),
    .next_id_i      (next_id),
    .full_i         (full),
    .unit_ready_i   (unit_ready),
    .hazard_vs1_i   (hazard_vs1),
    .hazard_vs2_i   (hazard_vs2),
    .hazard_vd_i    (hazard_vd),
    .pe_req_ready_i (pe_req_ready_i[`VSEQ_NR_LANES-1:0]),
    .req_ready_o    (req_ready_o),
    .issue_o        (issue),
    .issue_id_o     (issue_id),
    .issue_unit_o   (issue_unit),
    .pe_req_o       (pe_req_o),
    .pe_req_valid_o (pe_req_valid_o)
  );

endmodule

`default_nettype wire

//--- sim/vseq_checker.sv
/*
  Reference checker for the vector sequencer
  Samples every port on the rising clock edge and mirrors running IDs,
  register reader and writer lists, the hazard table and queue counters
  Expects at most one done pulse per unit and cycle, as the PE model sends
*/
`timescale 1ns/1ps
`default_nettype none

`include "vseq_defines.svh"

module vseq_checker (
  input  wire                                        clk_i,
  input  wire                                        rst_ni,
  input  vseq_pkg::seq_req_t                         seq_req_i,
  input  wire                                        req_valid_i,
  input  wire                                        req_ready_i,
  input  vseq_pkg::pe_req_t                          pe_req_i,
  input  wire                                        pe_req_valid_i,
  input  wire  [`VSEQ_NR_PES-1:0]                    pe_req_ready_i,
  input  vseq_pkg::vinsn_vec_t [`VSEQ_NR_PES-1:0]    pe_done_i,
  input  vseq_pkg::vinsn_vec_t [`VSEQ_NR_VINSN-1:0]  hazard_table_i,
  input  wire                                        idle_i,
  output logic [31:0]                                check_cnt_o,
  output logic [31:0]                                mismatch_cnt_o
);

  typedef struct packed {
    vseq_pkg::vinsn_vec_t vs1;
    vseq_pkg::vinsn_vec_t vs2;
    vseq_pkg::vinsn_vec_t vd;
  } hazards_t;

  // Queue depths in unit_e order
  localparam int DEPTH [3] = '{`VSEQ_ALU_DEPTH, `VSEQ_LD_DEPTH, `VSEQ_ST_DEPTH};

  // Widest compared value is the whole PE request
  localparam int VAL_W = $bits(vseq_pkg::pe_req_t);

  // Model state
  vseq_pkg::vinsn_vec_t   [`VSEQ_NR_PES-1:0]   run_m;
  vseq_pkg::vreg_access_t [`VSEQ_NR_VREGS-1:0] rd_m;
  vseq_pkg::vreg_access_t [`VSEQ_NR_VREGS-1:0] wr_m;
  vseq_pkg::vinsn_vec_t   [`VSEQ_NR_VINSN-1:0] table_m;
  int                                          cnt_m [3];
  logic                                        hold_m;
  vseq_pkg::pe_req_t                           exp_req;

  // Per-edge scratch values
  vseq_pkg::vinsn_vec_t running;
  vseq_pkg::unit_e      unit;
  hazards_t             hz;
  logic                 exp_ready;
  logic [2:0]           unit_done;
  int                   free_id;
  int                   checks = 0;
  int                   mismatches = 0;

  assign check_cnt_o    = checks;
  assign mismatch_cnt_o = mismatches;

  //////////////////////////////
  // Reference functions
  //////////////////////////////

  // RAW on the sources, WAR and WAW on vd
  // A WAR hit lands in all three vectors
  function automatic hazards_t expected_hazards(
    input vseq_pkg::seq_req_t                          req,
    input vseq_pkg::vreg_access_t [`VSEQ_NR_VREGS-1:0] rd,
    input vseq_pkg::vreg_access_t [`VSEQ_NR_VREGS-1:0] wr
  );
    hazards_t h;
    h = '0;
    if (req.use_vs1 && wr[req.vs1].valid) h.vs1[wr[req.vs1].vid] = 1'b1;
    if (req.use_vs2 && wr[req.vs2].valid) h.vs2[wr[req.vs2].vid] = 1'b1;
    if (req.use_vd && rd[req.vd].valid) begin
      h.vs1[rd[req.vd].vid] = 1'b1;
      h.vs2[rd[req.vd].vid] = 1'b1;
      h.vd[rd[req.vd].vid]  = 1'b1;
    end
    if (req.use_vd && wr[req.vd].valid) h.vd[wr[req.vd].vid] = 1'b1;
    return h;
  endfunction

  // Lowest ID not running or -1 when all are busy
  function automatic int lowest_free(input vseq_pkg::vinsn_vec_t run);
    for (int i = 0; i < `VSEQ_NR_VINSN; i++) begin
      if (!run[i]) return i;
    end
    return -1;
  endfunction

  task automatic check_val(input string name, input logic [VAL_W-1:0] exp_v,
                           input logic [VAL_W-1:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      mismatches++;
      $display("MISMATCH %s at %0t: expected %h, actual %h", name, $time, exp_v, act_v);
    end
  endtask

  //////////////////////////////
  // Compare and update
  //////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_m   = '0;
      rd_m    = '0;
      wr_m    = '0;
      table_m = '0;
      hold_m  = 1'b0;
      for (int u = 0; u < 3; u++) cnt_m[u] = 0;
    end else begin
      running = '0;
      for (int pe = 0; pe < `VSEQ_NR_PES; pe++) running |= run_m[pe];

      // List entries of retired IDs are gone
      for (int v = 0; v < `VSEQ_NR_VREGS; v++) begin
        rd_m[v].valid = rd_m[v].valid & running[rd_m[v].vid];
        wr_m[v].valid = wr_m[v].valid & running[wr_m[v].vid];
      end

      unit      = vseq_pkg::unit_of(seq_req_i.op);
      exp_ready = !hold_m && (running != '1) && (cnt_m[int'(unit)] < DEPTH[int'(unit)]);

      check_val("req_ready", 64'(exp_ready), 64'(req_ready_i));
      check_val("idle", 64'(running == '0), 64'(idle_i));
      check_val("pe_req_valid", 64'(hold_m), 64'(pe_req_valid_i));
      check_val("hazard_table", table_m, hazard_table_i);
      // Held request must not move under back-pressure
      if (hold_m) check_val("pe_req", exp_req, pe_req_i);

      // Table columns clear one edge after the ID frees
      for (int r = 0; r < `VSEQ_NR_VINSN; r++) table_m[r] &= running;

      for (int pe = 0; pe < `VSEQ_NR_PES; pe++) run_m[pe] &= ~pe_done_i[pe];
      unit_done[vseq_pkg::UNIT_ALU]   = |pe_done_i[0];
      unit_done[vseq_pkg::UNIT_LOAD]  = |pe_done_i[`VSEQ_NR_LANES];
      unit_done[vseq_pkg::UNIT_STORE] = |pe_done_i[`VSEQ_NR_LANES + 1];
      for (int u = 0; u < 3; u++) begin
        if (unit_done[u]) cnt_m[u]--;
      end

      // PE handshake ends the hold
      if (hold_m && (&pe_req_ready_i[`VSEQ_NR_LANES-1:0])) hold_m = 1'b0;

      if (req_valid_i && req_ready_i) begin
        free_id            = lowest_free(running);
        hz                 = expected_hazards(seq_req_i, rd_m, wr_m);
        exp_req.id         = vseq_pkg::vid_t'((free_id < 0) ? 0 : free_id);
        exp_req.op         = seq_req_i.op;
        exp_req.unit       = unit;
        exp_req.vs1        = seq_req_i.vs1;
        exp_req.use_vs1    = seq_req_i.use_vs1;
        exp_req.vs2        = seq_req_i.vs2;
        exp_req.use_vs2    = seq_req_i.use_vs2;
        exp_req.vd         = seq_req_i.vd;
        exp_req.use_vd     = seq_req_i.use_vd;
        exp_req.vl         = seq_req_i.vl;
        exp_req.hazard_vs1 = hz.vs1;
        exp_req.hazard_vs2 = hz.vs2;
        exp_req.hazard_vd  = hz.vd;

        if (seq_req_i.use_vd)  wr_m[seq_req_i.vd]  = '{vid: exp_req.id, valid: 1'b1};
        if (seq_req_i.use_vs1) rd_m[seq_req_i.vs1] = '{vid: exp_req.id, valid: 1'b1};
        if (seq_req_i.use_vs2) rd_m[seq_req_i.vs2] = '{vid: exp_req.id, valid: 1'b1};
        table_m[exp_req.id] = hz.vs1 | hz.vs2 | hz.vd;

        // ALU work lands in every lane
        if (unit == vseq_pkg::UNIT_LOAD) begin
          run_m[`VSEQ_NR_LANES][exp_req.id] = 1'b1;
        end else if (unit == vseq_pkg::UNIT_STORE) begin
          run_m[`VSEQ_NR_LANES + 1][exp_req.id] = 1'b1;
        end else begin
          for (int l = 0; l < `VSEQ_NR_LANES; l++) run_m[l][exp_req.id] = 1'b1;
        end
        cnt_m[int'(unit)]++;
        hold_m = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_vseq.sv
/*
  Testbench for the vector sequencer
  Directed RAW, WAR and WAW cases, a lane stall, a full ID set and a
  full load queue, then random traffic
  The PE model completes each unit in order, one ID per cycle at most
  Every wait gives up after TIMEOUT cycles
*/
`timescale 1ns/1ps
`default_nettype none

`include "vseq_defines.svh"

module tb_vseq;

  localparam int TIMEOUT   = 1000;
  localparam int NR_RANDOM = 300;

  logic                                      clk;
  logic                                      rst_n;
  vseq_pkg::seq_req_t                        seq_req;
  logic                                      req_valid;
  logic                                      req_ready;
  vseq_pkg::pe_req_t                         pe_req;
  logic                                      pe_req_valid;
  logic [`VSEQ_NR_PES-1:0]                   pe_req_ready;
  vseq_pkg::vinsn_vec_t [`VSEQ_NR_PES-1:0]   pe_done;
  vseq_pkg::vinsn_vec_t [`VSEQ_NR_VINSN-1:0] hazard_table;
  logic                                      idle;
  logic [31:0]                               check_cnt;
  logic [31:0]                               mismatch_cnt;
  int                                        timeout_cnt;
  // PE model controls
  logic                                      done_en;
  logic                                      lanes_en;

  vseq_top dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .seq_req_i      (seq_req),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .pe_req_o       (pe_req),
    .pe_req_valid_o (pe_req_valid),
    .pe_req_ready_i (pe_req_ready),
    .pe_done_i      (pe_done),
    .hazard_table_o (hazard_table),
    .idle_o         (idle)
  );

  vseq_checker i_checker (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .seq_req_i      (seq_req),
    .req_valid_i    (req_valid),
    .req_ready_i    (req_ready),
    .pe_req_i       (pe_req),
    .pe_req_valid_i (pe_req_valid),
    .pe_req_ready_i (pe_req_ready),
    .pe_done_i      (pe_done),
    .hazard_table_i (hazard_table),
    .idle_i         (idle),
    .check_cnt_o    (check_cnt),
    .mismatch_cnt_o (mismatch_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic finish_run();
    @(negedge clk);
    $display("Checks: %0d  mismatches: %0d  timeouts: %0d",
             check_cnt, mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0 && check_cnt > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // ALU ops use every operand, loads only vd and stores only vs1
  function automatic vseq_pkg::seq_req_t build_req(input vseq_pkg::vop_e op,
      input vseq_pkg::vreg_t vs1, input vseq_pkg::vreg_t vs2, input vseq_pkg::vreg_t vd);
    vseq_pkg::seq_req_t r;
    r.op      = op;
    r.vs1     = vs1;
    r.vs2     = vs2;
    r.vd      = vd;
    r.use_vs1 = (op != vseq_pkg::OP_LOAD);
    r.use_vs2 = (vseq_pkg::unit_of(op) == vseq_pkg::UNIT_ALU);
    r.use_vd  = (op != vseq_pkg::OP_STORE);
    r.vl      = 16'd128;
    return r;
  endfunction

  // Registers limited to eight so hazards come often
  function automatic vseq_pkg::seq_req_t random_req();
    vseq_pkg::seq_req_t r;
    r.op      = vseq_pkg::vop_e'($urandom % 5);
    r.vs1     = vseq_pkg::vreg_t'($urandom % 8);
    r.vs2     = vseq_pkg::vreg_t'($urandom % 8);
    r.vd      = vseq_pkg::vreg_t'($urandom % 8);
    r.use_vs1 = (($urandom % 2) != 0);
    r.use_vs2 = (($urandom % 2) != 0);
    r.use_vd  = (($urandom % 4) != 0);
    r.vl      = vseq_pkg::vl_t'($urandom);
    return r;
  endfunction

  task automatic send_req(input vseq_pkg::seq_req_t r);
    int waited;
    waited = 0;
    @(posedge clk);
    seq_req   <= r;
    req_valid <= 1'b1;
    @(posedge clk);
    while (!req_ready && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!req_ready) begin
      $display("ERROR: request not accepted within %0d cycles", TIMEOUT);
      timeout_cnt++;
      finish_run();
    end else begin
      req_valid <= 1'b0;
    end
  endtask

  // Request must wait until completions are switched back on
  task automatic send_then_release_done(input vseq_pkg::seq_req_t r);
    fork
      send_req(r);
      begin
        repeat (12) @(posedge clk);
        done_en <= 1'b1;
      end
    join
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(posedge clk);
    while (!(idle && !pe_req_valid) && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!(idle && !pe_req_valid)) begin
      $display("ERROR: sequencer did not drain within %0d cycles", TIMEOUT);
      timeout_cnt++;
      finish_run();
    end
  endtask

  //////////////////////////////
  // PE model
  //////////////////////////////

  initial begin : pe_model
    vseq_pkg::vid_t                          alu_q [$];
    vseq_pkg::vid_t                          ld_q [$];
    vseq_pkg::vid_t                          st_q [$];
    vseq_pkg::vinsn_vec_t [`VSEQ_NR_PES-1:0] done_nxt;
    vseq_pkg::vid_t                          id;
    pe_req_ready = '0;
    pe_done      = '0;
    forever begin
      @(posedge clk);
      done_nxt = '0;
      if (!rst_n) begin
        alu_q.delete();
        ld_q.delete();
        st_q.delete();
      end else begin
        // Taken requests queue up per unit
        if (pe_req_valid && (&pe_req_ready[`VSEQ_NR_LANES-1:0])) begin
          case (pe_req.unit)
            vseq_pkg::UNIT_LOAD:  ld_q.push_back(pe_req.id);
            vseq_pkg::UNIT_STORE: st_q.push_back(pe_req.id);
            default:              alu_q.push_back(pe_req.id);
          endcase
        end
        if (done_en) begin
          if (alu_q.size() > 0 && ($urandom % 3) == 0) begin
            id = alu_q.pop_front();
            for (int l = 0; l < `VSEQ_NR_LANES; l++) done_nxt[l][id] = 1'b1;
          end
          if (ld_q.size() > 0 && ($urandom % 3) == 0) begin
            id = ld_q.pop_front();
            done_nxt[`VSEQ_NR_LANES][id] = 1'b1;
          end
          if (st_q.size() > 0 && ($urandom % 3) == 0) begin
            id = st_q.pop_front();
            done_nxt[`VSEQ_NR_LANES + 1][id] = 1'b1;
          end
        end
      end
      pe_done <= done_nxt;
      for (int pe = 0; pe < `VSEQ_NR_PES; pe++) begin
        pe_req_ready[pe] <= lanes_en && (($urandom % 4) != 0);
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin : main_flow
    void'($urandom(32'h53f0_453e));
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    seq_req     = '0;
    done_en     = 1'b1;
    lanes_en    = 1'b1;
    timeout_cnt = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Lanes stalled while the first request is held
    done_en  <= 1'b0;
    lanes_en <= 1'b0;
    send_req(build_req(vseq_pkg::OP_ADD, 5'd1, 5'd2, 5'd3));
    fork
      send_req(build_req(vseq_pkg::OP_SUB, 5'd3, 5'd4, 5'd5));
      begin
        repeat (10) @(posedge clk);
        lanes_en <= 1'b1;
      end
    join
    // WAR on v1, then WAW on v5
    send_req(build_req(vseq_pkg::OP_MUL, 5'd6, 5'd7, 5'd1));
    send_req(build_req(vseq_pkg::OP_ADD, 5'd8, 5'd9, 5'd5));
    send_req(build_req(vseq_pkg::OP_LOAD, 5'd0, 5'd0, 5'd10));
    send_req(build_req(vseq_pkg::OP_LOAD, 5'd0, 5'd0, 5'd11));
    send_req(build_req(vseq_pkg::OP_STORE, 5'd10, 5'd0, 5'd0));
    send_req(build_req(vseq_pkg::OP_STORE, 5'd3, 5'd0, 5'd0));
    // All eight IDs busy
    send_then_release_done(build_req(vseq_pkg::OP_LOAD, 5'd0, 5'd0, 5'd12));
    wait_idle();

    // Two loads fill the load queue
    done_en <= 1'b0;
    send_req(build_req(vseq_pkg::OP_LOAD, 5'd0, 5'd0, 5'd13));
    send_req(build_req(vseq_pkg::OP_LOAD, 5'd0, 5'd0, 5'd14));
    send_then_release_done(build_req(vseq_pkg::OP_LOAD, 5'd0, 5'd0, 5'd13));
    wait_idle();

    for (int n = 0; n < NR_RANDOM; n++) begin
      send_req(random_req());
    end
    wait_idle();
    finish_run();
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/vseq_pkg.sv
source/vinsn_tracker.sv
source/vreg_scoreboard.sv
source/unit_queue_cnt.sv
source/vseq_issue.sv
source/vseq_top.sv
sim/vseq_checker.sv
sim/tb_vseq.sv

//--- Bender.yml
package:
  name: vseq

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/vseq_pkg.sv
      - source/vinsn_tracker.sv
      - source/vreg_scoreboard.sv
      - source/unit_queue_cnt.sv
      - source/vseq_issue.sv
      - source/vseq_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/vseq_checker.sv
      - sim/tb_vseq.sv
